/* icache.f */
+incdir+.
icache_pkg.sv
icache_if.sv
icache_dispatch.sv
icache_bank.sv
icache_mem_arbiter.sv
icache_top.sv
tb_icache.sv

/* icache_bank.sv */
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_bank (
    input logic clk,
    input logic rst,
    icache_bank_if.bank bank,
    icache_mem_if.bank mem
);

    icache_pkg::line_t lines [`ICACHE_LINES];

    icache_pkg::bank_state_t state_q;
    icache_pkg::bank_state_t state_d;

    logic [`ICACHE_ADDR_W-1:0] addr_q;
    icache_pkg::index_t req_index;
    icache_pkg::tag_t req_tag;
    icache_pkg::line_t rd_line;
    logic hit;
    logic fill;

    assign req_index = icache_pkg::addr_index(addr_q);
    assign req_tag = icache_pkg::addr_tag(addr_q);
    assign rd_line = lines[req_index];
    assign hit = rd_line.valid && (rd_line.tag == req_tag);

    assign fill = (state_q == icache_pkg::ALLOCATE) && mem.resp_ready;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            icache_pkg::IDLE:
            begin
                if (bank.req_valid)
                begin
                    state_d = icache_pkg::COMPARE;
                end
            end
            icache_pkg::COMPARE:
            begin
                state_d = hit ? icache_pkg::IDLE : icache_pkg::ALLOCATE;
            end
            icache_pkg::ALLOCATE:
            begin
                if (mem.resp_ready)
                begin
                    state_d = icache_pkg::RESPOND;
                end
            end
            icache_pkg::RESPOND:
            begin
                state_d = icache_pkg::IDLE;
            end
            default:
            begin
                state_d = icache_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= icache_pkg::IDLE;
        end
        else
        begin
            state_q <= state_d;
        end
    end

    // fetch address, held until the answer goes out
    always_ff @(posedge clk)
    begin
        if (state_q == icache_pkg::IDLE && bank.req_valid)
        begin
            addr_q <= bank.req_addr;
        end
    end

    // only the valid bits are cleared, tag and data stay
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `ICACHE_LINES; i++)
            begin
                lines[i].valid <= 1'b0;
            end
        end
        else if (fill)
        begin
            lines[req_index] <= '{valid: 1'b1, tag: req_tag, data: mem.resp_data};
        end
    end

    // hit answers from COMPARE, miss from RESPOND after the fill
    assign bank.resp_valid = (state_q == icache_pkg::COMPARE && hit)
        || (state_q == icache_pkg::RESPOND);
    assign bank.resp_data = rd_line.data;

    assign mem.req_valid = (state_q == icache_pkg::ALLOCATE);
    assign mem.req_addr = {addr_q[`ICACHE_ADDR_W-1:2], 2'b00};

    // an answer follows either a strobe (hit) or a memory fill
    a_resp_cause: assert property (@(posedge clk) disable iff (rst)
        bank.resp_valid |-> $past(bank.req_valid) || $past(mem.resp_ready));

    a_mem_hold: assert property (@(posedge clk) disable iff (rst)
        mem.req_valid && !mem.resp_ready |=> mem.req_valid && $stable(mem.req_addr));

endmodule

/* icache_defines.svh */
`ifndef ICACHE_DEFINES_SVH
`define ICACHE_DEFINES_SVH

// cache geometry

// banks, selected by address bits 3:2
`define ICACHE_NUM_BANKS 4

// one-word lines per bank
`define ICACHE_LINES 16

// bus widths

// fetch and memory address
`define ICACHE_ADDR_W 32

// instruction word
`define ICACHE_DATA_W 32

`endif

/* icache_dispatch.sv */
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_dispatch (
    input logic clk,
    input logic rst,
    input logic [`ICACHE_ADDR_W-1:0] cpu_req_addr,
    input logic cpu_req_valid,
    output logic [`ICACHE_DATA_W-1:0] cpu_req_data,
    output logic cpu_req_ready,
    icache_bank_if.dispatch banks [`ICACHE_NUM_BANKS]
);

    localparam int N = `ICACHE_NUM_BANKS;

    logic busy;
    logic strobe_q;
    logic accept;
    logic [`ICACHE_ADDR_W-1:0] addr_q;
    icache_pkg::bank_sel_t sel_q;

    logic [N-1:0] resp_valid_vec;
    logic [`ICACHE_DATA_W-1:0] resp_data_arr [N];
    logic sel_resp_valid;

    // busy stays set through the ready cycle so a held request is not taken twice
    assign accept = cpu_req_valid && !busy;

    for (genvar i = 0; i < N; i++)
    begin : g_bank
        assign banks[i].req_valid = strobe_q && (sel_q == icache_pkg::bank_sel_t'(i));
        assign banks[i].req_addr = addr_q;
        assign resp_valid_vec[i] = banks[i].resp_valid;
        assign resp_data_arr[i] = banks[i].resp_data;
    end

    assign sel_resp_valid = busy && resp_valid_vec[sel_q];

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            busy <= 1'b0;
            strobe_q <= 1'b0;
            cpu_req_ready <= 1'b0;
        end
        else
        begin
            strobe_q <= accept;
            cpu_req_ready <= sel_resp_valid;
            if (accept)
            begin
                busy <= 1'b1;
            end
            else if (cpu_req_ready)
            begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            addr_q <= cpu_req_addr;
            sel_q <= icache_pkg::addr_bank(cpu_req_addr);
        end
        if (sel_resp_valid)
        begin
            cpu_req_data <= resp_data_arr[sel_q];
        end
    end

    // a second strobe never goes out before the CPU has its answer
    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        strobe_q |=> (!strobe_q until cpu_req_ready));

    // only the bank that was strobed ever answers
    a_resp_from_sel: assert property (@(posedge clk) disable iff (rst)
        (|resp_valid_vec) |-> busy && (resp_valid_vec == (N'(1) << sel_q)));

endmodule

/* icache_if.sv */
`timescale 1ns/1ps
`include "icache_defines.svh"

// dispatcher to bank, one fetch at a time
interface icache_bank_if;

    // one-cycle strobe from the dispatcher
    logic req_valid;
    logic [`ICACHE_ADDR_W-1:0] req_addr;

    // one-cycle answer from the bank
    logic resp_valid;
    logic [`ICACHE_DATA_W-1:0] resp_data;

    modport dispatch (
        output req_valid,
        output req_addr,
        input resp_valid,
        input resp_data
    );

    modport bank (
        input req_valid,
        input req_addr,
        output resp_valid,
        output resp_data
    );

endinterface

// bank miss request to the memory arbiter
interface icache_mem_if;

    // level, held until resp_ready
    logic req_valid;
    logic [`ICACHE_ADDR_W-1:0] req_addr;

    logic resp_ready;
    logic [`ICACHE_DATA_W-1:0] resp_data;

    modport bank (
        output req_valid,
        output req_addr,
        input resp_ready,
        input resp_data
    );

    modport arbiter (
        input req_valid,
        input req_addr,
        output resp_ready,
        output resp_data
    );

endinterface

/* icache_mem_arbiter.sv */
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_mem_arbiter (
    input logic clk,
    input logic rst,
    icache_mem_if.arbiter reqs [`ICACHE_NUM_BANKS],
    output logic [`ICACHE_ADDR_W-1:0] mem_req_addr,
    output logic mem_req_valid,
    input logic [`ICACHE_DATA_W-1:0] mem_req_data,
    input logic mem_req_ready
);

    localparam int N = `ICACHE_NUM_BANKS;

    logic [N-1:0] req_vec;
    logic [`ICACHE_ADDR_W-1:0] req_addr_arr [N];

    icache_pkg::bank_sel_t ptr_q;
    icache_pkg::bank_sel_t served;
    logic [N-1:0] grant_q;
    logic [N-1:0] pick;
    logic [N-1:0] grant;

    for (genvar i = 0; i < N; i++)
    begin : g_port
        assign req_vec[i] = reqs[i].req_valid;
        assign req_addr_arr[i] = reqs[i].req_addr;
        assign reqs[i].resp_ready = grant[i] && mem_req_ready;
        assign reqs[i].resp_data = grant[i] ? mem_req_data : '0;
    end

    // first requester at or after the pointer
    always_comb
    begin : p_pick
        int idx;
        pick = '0;
        for (int k = 0; k < N; k++)
        begin
            idx = (int'(ptr_q) + k) % N;
            if (req_vec[idx] && pick == '0)
            begin
                pick[idx] = 1'b1;
            end
        end
    end

    // a fresh pick goes out the same cycle, no added latency
    assign grant = (grant_q != '0) ? grant_q : pick;
    assign mem_req_valid = |(grant & req_vec);

    always_comb
    begin
        mem_req_addr = '0;
        served = '0;
        for (int i = 0; i < N; i++)
        begin
            if (grant[i])
            begin
                mem_req_addr = req_addr_arr[i];
                served = icache_pkg::bank_sel_t'(i);
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            grant_q <= '0;
            ptr_q <= '0;
        end
        else if (mem_req_valid && mem_req_ready)
        begin
            grant_q <= '0;
            ptr_q <= icache_pkg::bank_sel_t'((int'(served) + 1) % N);
        end
        else if (grant_q == '0 && mem_req_valid)
        begin
            // lock until memory answers
            grant_q <= pick;
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot0(grant));

    a_grant_held: assert property (@(posedge clk) disable iff (rst)
        mem_req_valid && !mem_req_ready |=> $stable(grant) && mem_req_valid);

endmodule

/* icache_pkg.sv */
`include "icache_defines.svh"

package icache_pkg;

    // address split: tag | index | bank select | byte offset
    localparam int OFFSET_W = $clog2(`ICACHE_DATA_W / 8);
    localparam int BSEL_W = $clog2(`ICACHE_NUM_BANKS);
    localparam int INDEX_W = $clog2(`ICACHE_LINES);
    localparam int TAG_W = `ICACHE_ADDR_W - OFFSET_W - BSEL_W - INDEX_W;

    typedef logic [BSEL_W-1:0] bank_sel_t;
    typedef logic [INDEX_W-1:0] index_t;
    typedef logic [TAG_W-1:0] tag_t;

    // one cache entry, 57 bits
    typedef struct packed {
        logic valid;
        tag_t tag;
        logic [`ICACHE_DATA_W-1:0] data;
    } line_t;

    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        ALLOCATE,
        RESPOND
    } bank_state_t;

    function automatic bank_sel_t addr_bank(input logic [`ICACHE_ADDR_W-1:0] addr);
        return addr[OFFSET_W +: BSEL_W];
    endfunction

    function automatic index_t addr_index(input logic [`ICACHE_ADDR_W-1:0] addr);
        return addr[OFFSET_W + BSEL_W +: INDEX_W];
    endfunction

    function automatic tag_t addr_tag(input logic [`ICACHE_ADDR_W-1:0] addr);
        return addr[`ICACHE_ADDR_W-1 -: TAG_W];
    endfunction

endpackage

/* icache_top.sv */
`timescale 1ns/1ps
`include "icache_defines.svh"

module icache_top (
    input logic clk,
    input logic rst,

    // CPU fetch port
    input logic [`ICACHE_ADDR_W-1:0] cpu_req_addr,
    input logic cpu_req_valid,
    output logic [`ICACHE_DATA_W-1:0] cpu_req_data,
    output logic cpu_req_ready,

    // memory port
    output logic [`ICACHE_ADDR_W-1:0] mem_req_addr,
    output logic mem_req_valid,
    input logic [`ICACHE_DATA_W-1:0] mem_req_data,
    input logic mem_req_ready
);

    icache_bank_if bank_ifs [`ICACHE_NUM_BANKS] ();
    icache_mem_if mem_ifs [`ICACHE_NUM_BANKS] ();

    icache_dispatch u_dispatch (
        .clk (clk),
        .rst (rst),
        .cpu_req_addr (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_data (cpu_req_data),
        .cpu_req_ready (cpu_req_ready),
        .banks (bank_ifs)
    );

    for (genvar i = 0; i < `ICACHE_NUM_BANKS; i++)
    begin : g_bank
        icache_bank u_bank (
            .clk (clk),
            .rst (rst),
            .bank (bank_ifs[i]),
            .mem (mem_ifs[i])
        );
    end

    // all banks share the one memory port
    icache_mem_arbiter u_arbiter (
        .clk (clk),
        .rst (rst),
        .reqs (mem_ifs),
        .mem_req_addr (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .mem_req_data (mem_req_data),
        .mem_req_ready (mem_req_ready)
    );

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_icache -f icache.f -o sim_icache

# the run may stop with a nonzero status, the log decides
./obj_dir/sim_icache > sim.log 2>&1 || true
cat sim.log

if grep -q "^STATUS: PASS$" sim.log
then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

/* tb_icache.sv */
`timescale 1ns/1ps

module tb_icache;

    localparam int CLK_PERIOD = 40;
    localparam int RESET_CYCLES = 10;
    localparam int N_RANDOM = 300;
    localparam int N_RANDOM_AFTER = 100;
    localparam int N_DIRECTED = 20;
    localparam int TOTAL_FETCHES = N_RANDOM + N_RANDOM_AFTER + N_DIRECTED;
    // accept, strobe, compare, up to 7 in allocate, respond, ready, drop
    localparam int MISS_CYCLES = 16;
    localparam int TIMEOUT_CYCLES = TOTAL_FETCHES * MISS_CYCLES + 4 * RESET_CYCLES + 50;

    logic clk = 1'b0;
    logic rst;
    logic [31:0] cpu_req_addr;
    logic cpu_req_valid;
    logic [31:0] cpu_req_data;
    logic cpu_req_ready;
    logic [31:0] mem_req_addr;
    logic mem_req_valid;
    logic [31:0] mem_req_data = 32'h0;
    logic mem_req_ready = 1'b0;

    int seed = 63;

    // memory model state
    int mem_wait = 0;
    int mem_rises = 0;
    logic prev_valid = 1'b0;
    logic prev_ready = 1'b0;
    logic [31:0] prev_addr = 32'h0;
    logic [31:0] fetch_addr = 32'h0;

    // reference cache indexed by bank and line
    logic model_valid [4][16];
    logic [23:0] model_tag [4][16];

    icache_top dut0 (
        .clk (clk),
        .rst (rst),
        .cpu_req_addr (cpu_req_addr),
        .cpu_req_valid (cpu_req_valid),
        .cpu_req_data (cpu_req_data),
        .cpu_req_ready (cpu_req_ready),
        .mem_req_addr (mem_req_addr),
        .mem_req_valid (mem_req_valid),
        .mem_req_data (mem_req_data),
        .mem_req_ready (mem_req_ready)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("CHECK FAILED %s: expected %h, actual %h", name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // memory contents as a fixed scramble of the word address
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] x;
        x = a ^ 32'h6b3c_91e5;
        x = x ^ {x[18:0], x[31:19]};
        x = x * 32'h0019_660d;
        return x ^ {a[15:0], a[31:16]};
    endfunction

    // memory model answering after 0 to 5 extra cycles and checking the request rule
    always @(posedge clk)
    begin
        if (rst)
        begin
            mem_req_ready <= 1'b0;
            prev_valid <= 1'b0;
            prev_ready <= 1'b0;
            mem_wait <= 0;
        end
        else
        begin
            mem_req_ready <= 1'b0;
            prev_valid <= mem_req_valid;
            prev_ready <= mem_req_ready;
            prev_addr <= mem_req_addr;
            if (prev_valid && !prev_ready)
            begin
                check("mem_req_valid", 32'd1, 32'(mem_req_valid));
                check("mem_req_addr", prev_addr, mem_req_addr);
            end
            if (prev_ready)
            begin
                check("mem_req_valid", 32'd0, 32'(mem_req_valid));
            end
            if (mem_req_valid && !prev_valid)
            begin
                mem_rises <= mem_rises + 1;
            end
            if (mem_req_valid && !mem_req_ready)
            begin
                if (mem_wait == 0)
                begin
                    check("mem_req_addr", {fetch_addr[31:2], 2'b00}, mem_req_addr);
                    mem_req_ready <= 1'b1;
                    mem_req_data <= mem_word(mem_req_addr);
                    mem_wait <= {$random(seed)} % 6;
                end
                else
                begin
                    mem_wait <= mem_wait - 1;
                end
            end
        end
    end

    task automatic clear_model();
        for (int b = 0; b < 4; b++)
        begin
            for (int i = 0; i < 16; i++)
            begin
                model_valid[b][i] = 1'b0;
                model_tag[b][i] = 24'h0;
            end
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        rst <= 1'b1;
        cpu_req_valid <= 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        clear_model();
    endtask

    // one fetch compared with the reference model
    task automatic do_fetch(input logic [31:0] addr);
        logic [1:0] b;
        logic [3:0] idx;
        logic [23:0] tag;
        logic miss;
        int rises_before;
        int waited;
        b = addr[3:2];
        idx = addr[7:4];
        tag = addr[31:8];
        miss = !(model_valid[b][idx] && model_tag[b][idx] == tag);
        fetch_addr = addr;
        rises_before = mem_rises;
        waited = 0;
        @(posedge clk);
        cpu_req_addr <= addr;
        cpu_req_valid <= 1'b1;
        do
        begin
            @(negedge clk);
            waited++;
        end
        while (!cpu_req_ready);
        check("cpu_req_data", mem_word({addr[31:2], 2'b00}), cpu_req_data);
        check("mem_req_valid rises", 32'(miss), 32'(mem_rises - rises_before));
        // a hit shows ready on the fourth falling edge after the drive edge
        if (!miss)
        begin
            check("cpu_req_ready latency", 32'd4, 32'(waited));
        end
        model_valid[b][idx] = 1'b1;
        model_tag[b][idx] = tag;
        @(posedge clk);
        cpu_req_valid <= 1'b0;
        // ready is a single-cycle pulse
        @(negedge clk);
        check("cpu_req_ready", 32'd0, 32'(cpu_req_ready));
    endtask

    // small address pool so that hits, misses and conflicts all occur
    task automatic random_fetches(input int count);
        logic [31:0] addr;
        for (int n = 0; n < count; n++)
        begin
            @(negedge clk);
            addr = 32'h0001_0000 | (32'($random(seed)) & 32'h0000_03ff);
            do_fetch(addr);
        end
    endtask

    initial
    begin
        rst = 1'b1;
        cpu_req_addr = 32'h0;
        cpu_req_valid = 1'b0;
        apply_reset();

        // 1234 and 5634 share bank 1 line 3 while 1238 and 1244 sit elsewhere
        do_fetch(32'h0000_1234);
        do_fetch(32'h0000_1236);
        do_fetch(32'h0000_1238);
        do_fetch(32'h0000_1244);
        for (int n = 0; n < 3; n++)
        begin
            do_fetch(32'h0000_5634);
            do_fetch(32'h0000_1234);
        end
        do_fetch(32'h0000_1238);
        do_fetch(32'h0000_1244);

        random_fetches(N_RANDOM);

        do_fetch(32'h0000_1234);
        do_fetch(32'h0000_1238);
        apply_reset();
        // resident before reset so these miss again
        do_fetch(32'h0000_1234);
        do_fetch(32'h0000_1238);
        do_fetch(32'h0000_1234);

        random_fetches(N_RANDOM_AFTER);

        $display("STATUS: PASS");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("watchdog: the fetches did not finish in the expected time");
        $display("STATUS: FAIL");
        $fatal(1, "timeout");
    end

endmodule
